//--- Bender.yml
package:
  name: rv32i_core

sources:
  - common/corePkg.sv
  - rtl/ProgramCounter.sv
  - decode/InstrDecoder.sv
  - decode/DecodeStage.sv
  - rtl/RegFile.sv
  - rtl/OperandStage.sv
  - rtl/IntALU.sv
  - rtl/Core.sv
  - target: test
    files:
      - tb/CoreChecker.sv
      - tb/CoreTb.sv

//--- common/corePkg.sv
package corePkg;

    localparam int XLEN = 32;
    localparam int SQN_W = 6;
    localparam int REG_W = 5;

    // Operations of the supported RV32I subset
    typedef enum logic [5:0] {
        OP_INVALID,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_JAL,
        OP_JALR
    } Opcode;

    typedef struct packed {
        Opcode            opcode;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rd;      // Zero for branches and invalid words
        logic [XLEN-1:0]  imm;     // Sign extended
        logic [XLEN-1:0]  pc;
        logic [SQN_W-1:0] sqN;
        logic             valid;
    } DecodedUop;

    typedef struct packed {
        Opcode            opcode;
        logic [XLEN-1:0]  srcA;
        logic [XLEN-1:0]  srcB;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  pc;
        logic [REG_W-1:0] rd;
        logic [SQN_W-1:0] sqN;
        logic             valid;
    } OperandUop;

    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  result;
        logic [SQN_W-1:0] sqN;
    } ResultBus;

    typedef struct packed {
        logic             taken;
        logic [XLEN-1:0]  target;
        logic [SQN_W-1:0] sqN;    // Sequence number of the branch itself
    } Redirect;

endpackage

//--- decode/DecodeStage.sv
`timescale 1ns/1ns

module DecodeStage (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:0]        instr,
    input  logic [31:0]        pc,
    input  corePkg::Redirect   redirect,
    output corePkg::DecodedUop decUop
);
    import corePkg::*;

    DecodedUop decoded;
    DecodedUop decReg;
    logic slotLive;
    logic [SQN_W-1:0] nextSqN;

    InstrDecoder decoder (
        .instr(instr),
        .pc(pc),
        .uop(decoded)
    );

    always_ff @(posedge clk) begin
        decReg <= decoded;
        decReg.sqN <= nextSqN;  // Stamp the number at capture time
    end

    // slotLive marks whether the slot now held in decReg survived a squash
    always_ff @(posedge clk) begin
        if (rst) begin
            slotLive <= 1'b0;
            nextSqN <= '0;
        end else if (redirect.taken) begin
            slotLive <= 1'b0;
            nextSqN <= redirect.sqN + 1'b1;  // Numbering restarts after the branch
        end else begin
            slotLive <= 1'b1;
            if (decoded.valid) begin
                nextSqN <= nextSqN + 1'b1;  // Invalid words are bubbles and take no number
            end
        end
    end

    always_comb begin
        decUop = decReg;
        decUop.valid = decReg.valid && slotLive;
    end

endmodule

//--- decode/InstrDecoder.sv
`timescale 1ns/1ns

module InstrDecoder (
    input  logic [31:0]        instr,
    input  logic [31:0]        pc,
    output corePkg::DecodedUop uop
);
    import corePkg::*;

    logic [6:0] major;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immJ;

    assign major = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immU = {instr[31:12], 12'b0};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        uop = '0;
        uop.opcode = OP_INVALID;
        uop.rs1 = instr[19:15];
        uop.rs2 = instr[24:20];
        uop.rd = instr[11:7];
        uop.pc = pc;

        case (major)
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: uop.opcode = OP_ADD;
                    10'b0100000_000: uop.opcode = OP_SUB;
                    10'b0000000_010: uop.opcode = OP_SLT;
                    10'b0000000_100: uop.opcode = OP_XOR;
                    10'b0000000_110: uop.opcode = OP_OR;
                    10'b0000000_111: uop.opcode = OP_AND;
                    default: uop.opcode = OP_INVALID;
                endcase
            end
            7'b0010011: begin
                uop.imm = immI;
                case (funct3)
                    3'b000: uop.opcode = OP_ADDI;
                    3'b100: uop.opcode = OP_XORI;
                    3'b110: uop.opcode = OP_ORI;
                    3'b111: uop.opcode = OP_ANDI;
                    default: uop.opcode = OP_INVALID;  // SLTI and shifts are not supported
                endcase
            end
            7'b0110111: begin
                uop.opcode = OP_LUI;
                uop.imm = immU;
            end
            7'b1100011: begin
                uop.imm = immB;
                case (funct3)
                    3'b000: uop.opcode = OP_BEQ;
                    3'b001: uop.opcode = OP_BNE;
                    3'b100: uop.opcode = OP_BLT;
                    default: uop.opcode = OP_INVALID;
                endcase
            end
            7'b1101111: begin
                uop.opcode = OP_JAL;
                uop.imm = immJ;
            end
            7'b1100111: begin
                uop.imm = immI;
                uop.opcode = (funct3 == 3'b000) ? OP_JALR : OP_INVALID;
            end
            default: uop.opcode = OP_INVALID;
        endcase

        // Branches have no destination, and a bubble must never look like a write
        if (uop.opcode inside {OP_BEQ, OP_BNE, OP_BLT, OP_INVALID}) begin
            uop.rd = '0;
        end
        uop.valid = (uop.opcode != OP_INVALID);
    end

endmodule

//--- project.f
common/corePkg.sv
rtl/ProgramCounter.sv
decode/InstrDecoder.sv
decode/DecodeStage.sv
rtl/RegFile.sv
rtl/OperandStage.sv
rtl/IntALU.sv
rtl/Core.sv
tb/CoreChecker.sv
tb/CoreTb.sv

//--- rtl/Core.sv
`timescale 1ns/1ns

module Core #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       instr,
    output logic [31:0]       pc,
    output corePkg::ResultBus wb
);
    import corePkg::*;

    DecodedUop decUop;
    OperandUop opUop;
    ResultBus exResult;
    Redirect redirect;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;

    ProgramCounter #(
        .RESET_PC(RESET_PC)
    ) progCnt (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .pc(pc)
    );

    DecodeStage decode (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .redirect(redirect),
        .decUop(decUop)
    );

    RegFile rf (
        .clk(clk),
        .rst(rst),
        .rs1(rs1),
        .rs2(rs2),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .wb(wb)
    );

    OperandStage operand (
        .clk(clk),
        .rst(rst),
        .decUop(decUop),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .rs1(rs1),
        .rs2(rs2),
        .exResult(exResult),
        .wb(wb),
        .redirect(redirect),
        .opUop(opUop)
    );

    IntALU ialu (
        .clk(clk),
        .rst(rst),
        .opUop(opUop),
        .exResult(exResult),
        .wb(wb),
        .redirect(redirect)
    );

endmodule

//--- rtl/IntALU.sv
`timescale 1ns/1ns

module IntALU (
    input  logic               clk,
    input  logic               rst,
    input  corePkg::OperandUop opUop,
    output corePkg::ResultBus  exResult,
    output corePkg::ResultBus  wb,
    output corePkg::Redirect   redirect
);
    import corePkg::*;

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] linkPc;
    logic [XLEN-1:0] jalrSum;
    logic [XLEN-1:0] result;
    logic writesRd;
    logic condTaken;

    assign srcA = opUop.srcA;
    assign srcB = opUop.srcB;
    assign linkPc = opUop.pc + 32'd4;
    assign jalrSum = srcA + opUop.imm;

    always_comb begin
        result = '0;
        writesRd = 1'b1;
        condTaken = 1'b0;
        case (opUop.opcode)
            OP_ADD: result = srcA + srcB;
            OP_SUB: result = srcA - srcB;
            OP_AND: result = srcA & srcB;
            OP_OR: result = srcA | srcB;
            OP_XOR: result = srcA ^ srcB;
            OP_SLT: result = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            OP_ADDI: result = srcA + opUop.imm;
            OP_ANDI: result = srcA & opUop.imm;
            OP_ORI: result = srcA | opUop.imm;
            OP_XORI: result = srcA ^ opUop.imm;
            OP_LUI: result = opUop.imm;
            OP_JAL, OP_JALR: begin
                result = linkPc;
                condTaken = 1'b1;
            end
            OP_BEQ: begin
                writesRd = 1'b0;
                condTaken = (srcA == srcB);
            end
            OP_BNE: begin
                writesRd = 1'b0;
                condTaken = (srcA != srcB);
            end
            OP_BLT: begin
                writesRd = 1'b0;
                condTaken = $signed(srcA) < $signed(srcB);
            end
            default: writesRd = 1'b0;
        endcase
    end

    assign exResult.valid = opUop.valid && writesRd && (opUop.rd != '0);
    assign exResult.rd = opUop.rd;
    assign exResult.result = result;
    assign exResult.sqN = opUop.sqN;

    assign redirect.taken = opUop.valid && condTaken;
    assign redirect.target = (opUop.opcode == OP_JALR) ? {jalrSum[XLEN-1:1], 1'b0}
                                                       : opUop.pc + opUop.imm;
    assign redirect.sqN = opUop.sqN;

    always_ff @(posedge clk) begin
        wb <= exResult;
        if (rst) begin
            wb.valid <= 1'b0;
        end
    end

endmodule

//--- rtl/OperandStage.sv
`timescale 1ns/1ns

module OperandStage (
    input  logic               clk,
    input  logic               rst,
    input  corePkg::DecodedUop decUop,
    input  logic [31:0]        rdata1,
    input  logic [31:0]        rdata2,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    input  corePkg::ResultBus  exResult,
    input  corePkg::ResultBus  wb,
    input  corePkg::Redirect   redirect,
    output corePkg::OperandUop opUop
);
    import corePkg::*;

    OperandUop opNext;

    // Youngest producer wins: Execute, then Writeback, then the register file
    function automatic logic [XLEN-1:0] pickSource(
        input logic [REG_W-1:0] rs,
        input logic [XLEN-1:0]  rfData,
        input ResultBus         ex,
        input ResultBus         wbBus
    );
        if (rs == '0) begin
            return '0;
        end else if (ex.valid && ex.rd == rs) begin
            return ex.result;
        end else if (wbBus.valid && wbBus.rd == rs) begin
            return wbBus.result;
        end
        return rfData;
    endfunction

    assign rs1 = decUop.rs1;
    assign rs2 = decUop.rs2;

    always_comb begin
        opNext.opcode = decUop.opcode;
        opNext.srcA = pickSource(decUop.rs1, rdata1, exResult, wb);
        opNext.srcB = pickSource(decUop.rs2, rdata2, exResult, wb);
        opNext.imm = decUop.imm;
        opNext.pc = decUop.pc;
        opNext.rd = decUop.rd;
        opNext.sqN = decUop.sqN;
        opNext.valid = decUop.valid;
    end

    always_ff @(posedge clk) begin
        opUop <= opNext;
        if (rst || redirect.taken) begin
            opUop.valid <= 1'b0;  // Slot behind a taken branch is dropped
        end
    end

endmodule

//--- rtl/ProgramCounter.sv
`timescale 1ns/1ns

module ProgramCounter #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic             clk,
    input  logic             rst,
    input  corePkg::Redirect redirect,
    output logic [31:0]      pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect.taken) begin
            pc <= redirect.target;  // Target fetch shows up one cycle after the branch
        end else begin
            pc <= pc + 32'd4;
        end
    end

endmodule

//--- rtl/RegFile.sv
`timescale 1ns/1ns

module RegFile (
    input  logic              clk,
    input  logic              rst,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    output logic [31:0]       rdata1,
    output logic [31:0]       rdata2,
    input  corePkg::ResultBus wb
);
    import corePkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // The write lands at the edge, so same-cycle readers rely on forwarding
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- tb/CoreChecker.sv
`timescale 1ns/1ns

module CoreChecker #(
    parameter logic [31:0] RESET_PC = 32'h0,
    parameter int PROG_LEN = 48
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              halted,
    input  logic [31:0]       pc,
    input  corePkg::ResultBus wb,
    input  logic [31:0]       prog [PROG_LEN+1],
    output int                errorCount,
    output int                checkCount
);
    import corePkg::*;

    ResultBus expQ[$];
    logic wasRst;
    int errors = 0;
    int checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    // Instruction-set model: walks the program from the reset pc to the halt word
    task automatic buildModel();
        logic [31:0] x [32];
        logic [31:0] mpc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] val;
        logic [31:0] npc;
        logic [SQN_W-1:0] sq;
        logic known;
        logic writes;
        logic taken;
        ResultBus e;
        int steps;
        expQ.delete();
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        mpc = RESET_PC;
        sq = '0;
        steps = 0;
        while (mpc != RESET_PC + 4 * PROG_LEN && steps < 4 * PROG_LEN) begin
            w = prog[(mpc - RESET_PC) >> 2];
            a = x[w[19:15]];
            b = x[w[24:20]];
            immI = {{20{w[31]}}, w[31:20]};
            immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            npc = mpc + 32'd4;
            known = 1'b1;
            writes = 1'b1;
            taken = 1'b0;
            val = '0;
            case (w[6:0])
                7'b0110011: begin
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: val = a + b;
                        10'b0100000_000: val = a - b;
                        10'b0000000_111: val = a & b;
                        10'b0000000_110: val = a | b;
                        10'b0000000_100: val = a ^ b;
                        10'b0000000_010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: known = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    case (w[14:12])
                        3'b000: val = a + immI;
                        3'b100: val = a ^ immI;
                        3'b110: val = a | immI;
                        3'b111: val = a & immI;
                        default: known = 1'b0;
                    endcase
                end
                7'b0110111: val = {w[31:12], 12'b0};
                7'b1100011: begin
                    writes = 1'b0;
                    case (w[14:12])
                        3'b000: taken = (a == b);
                        3'b001: taken = (a != b);
                        3'b100: taken = ($signed(a) < $signed(b));
                        default: known = 1'b0;
                    endcase
                    if (taken) begin
                        npc = mpc + immB;
                    end
                end
                7'b1101111: begin
                    val = mpc + 32'd4;
                    npc = mpc + immJ;
                end
                7'b1100111: begin
                    val = mpc + 32'd4;
                    npc = (a + immI) & ~32'd1;
                    known = (w[14:12] == 3'b000);
                end
                default: known = 1'b0;
            endcase
            if (known) begin
                if (writes && w[11:7] != 5'd0) begin
                    x[w[11:7]] = val;
                    e.valid = 1'b1;
                    e.rd = w[11:7];
                    e.result = val;
                    e.sqN = sq;
                    expQ.push_back(e);
                end
                sq = sq + 1'b1;  // Branches and x0 writes still take a number
            end else begin
                npc = mpc + 32'd4;  // Unsupported words fall through as bubbles
            end
            mpc = npc;
            steps++;
        end
    endtask

    always @(posedge clk) begin : compare
        ResultBus head;
        wasRst <= rst;
        if (rst) begin
            buildModel();
        end else begin
            if (wasRst) begin
                checks++;
                if (pc != RESET_PC) begin
                    errors++;
                    $display("mismatch at %0t: pc %h after reset, expected %h", $time, pc, RESET_PC);
                end
            end
            if (wb.valid) begin
                checks++;
                if (expQ.size() == 0) begin
                    errors++;
                    $display("writeback to x%0d at %0t was not expected by the model",
                             wb.rd, $time);
                end else begin
                    head = expQ.pop_front();
                    if (wb.rd != head.rd || wb.result != head.result || wb.sqN != head.sqN) begin
                        errors++;
                        $display("mismatch at %0t: wb x%0d=%h sqN %0d, expected x%0d=%h sqN %0d",
                                 $time, wb.rd, wb.result, wb.sqN, head.rd, head.result, head.sqN);
                    end
                end
            end
            if (halted && expQ.size() != 0) begin
                errors++;
                $display("%0d expected writebacks were missing when the program halted",
                         expQ.size());
            end
        end
    end

endmodule

//--- tb/CoreTb.sv
`timescale 1ns/1ns

module CoreTb;
    import corePkg::*;

    localparam logic [31:0] RESET_PC = 32'h0;
    localparam int PROG_LEN = 48;
    localparam int NUM_PROGS = 4;
    localparam int TIMEOUT_CYCLES = NUM_PROGS * ((PROG_LEN + 1) * 6 + 40);
    localparam logic [31:0] HALT_WORD = 32'h0000006f;  // JAL x0,0
    localparam logic [17:0] R_F3 = {3'b010, 3'b100, 3'b110, 3'b111, 3'b000, 3'b000};
    localparam logic [11:0] I_F3 = {3'b111, 3'b110, 3'b100, 3'b000};
    localparam logic [8:0] B_F3 = {3'b100, 3'b001, 3'b000};

    logic clk;
    logic rst;
    logic halted;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] fetchIdx;
    ResultBus wb;
    logic [31:0] prog [PROG_LEN+1];
    logic jalrSlot [PROG_LEN+1];
    logic pairHead [PROG_LEN+1];
    int seed;
    int cycles = 0;
    int errorCount;
    int checkCount;

    // Instruction memory answers the current pc in the same cycle
    assign fetchIdx = (pc - RESET_PC) >> 2;
    assign instr = (fetchIdx <= PROG_LEN) ? prog[fetchIdx] : 32'h0;

    Core #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .wb(wb)
    );

    CoreChecker #(.RESET_PC(RESET_PC), .PROG_LEN(PROG_LEN)) coreCheck (
        .clk(clk),
        .rst(rst),
        .halted(halted),
        .pc(pc),
        .wb(wb),
        .prog(prog),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    function automatic int randBelow(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] randReg();
        logic [31:0] r;
        r = $random(seed);
        return {2'b00, r[2:0]};  // Only x0 to x7, so dependencies are frequent
    endfunction

    function automatic logic [31:0] encodeI(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                            logic [4:0] rs1, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeB(logic [12:0] off, logic [2:0] f3, logic [4:0] rs1,
                                            logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encodeJ(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic int pickTarget(int from);
        int t;
        t = from + randBelow(PROG_LEN + 1 - from);
        if (jalrSlot[t]) begin
            t = t + 1;  // Jumping onto a JALR would skip the ADDI that sets its base
        end
        return t;
    endfunction

    task automatic genProgram();
        int i;
        int t;
        int sel;
        int k;
        logic [4:0] rd;
        logic [4:0] base;
        logic [31:0] r;
        for (i = 0; i <= PROG_LEN; i++) begin
            jalrSlot[i] = 1'b0;
            pairHead[i] = 1'b0;
        end
        i = 0;
        while (i < PROG_LEN - 1) begin
            if (randBelow(12) == 0) begin
                pairHead[i] = 1'b1;
                jalrSlot[i + 1] = 1'b1;
                i = i + 2;
            end else begin
                i = i + 1;
            end
        end
        for (i = 0; i < PROG_LEN; i++) begin
            r = $random(seed);
            sel = randBelow(16);
            k = randBelow(6);
            rd = randReg();
            if (pairHead[i]) begin
                base = 5'(1 + randBelow(7));
                t = pickTarget(i + 2);
                prog[i] = encodeI(12'(RESET_PC + t * 4), 3'b000, base, 5'd0, 7'b0010011);
                prog[i + 1] = encodeI(12'd0, 3'b000, rd, base, 7'b1100111);
            end else if (!jalrSlot[i]) begin
                if (sel == 0) begin
                    prog[i] = {r[31:7], 7'b0000011};  // The load major opcode is outside the subset
                end else if (sel <= 2) begin
                    t = pickTarget(i + 1);
                    prog[i] = encodeB(13'((t - i) * 4), B_F3[(k % 3) * 3 +: 3], randReg(),
                                      randReg());
                end else if (sel == 3) begin
                    t = pickTarget(i + 1);
                    prog[i] = encodeJ(21'((t - i) * 4), rd);
                end else if (sel == 4) begin
                    prog[i] = {r[31:12], rd, 7'b0110111};
                end else if (sel <= 9) begin
                    prog[i] = {(k == 1) ? 7'b0100000 : 7'b0000000, randReg(), randReg(),
                               R_F3[k * 3 +: 3], rd, 7'b0110011};
                end else begin
                    prog[i] = encodeI(r[11:0], I_F3[(k % 4) * 3 +: 3], rd, randReg(), 7'b0010011);
                end
            end
        end
        prog[PROG_LEN] = HALT_WORD;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles before the last program halted", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        halted = 1'b0;
        seed = 77;
        for (int p = 0; p < NUM_PROGS; p++) begin
            genProgram();
            rst <= 1'b1;
            repeat (8) @(posedge clk);
            rst <= 1'b0;
            // The fetch reaches halt+8 only once the halt JAL is on the real path
            while (pc != RESET_PC + 4 * PROG_LEN + 8) begin
                @(posedge clk);
            end
            repeat (2) @(posedge clk);
            halted <= 1'b1;
            @(posedge clk);
            halted <= 1'b0;
        end
        @(negedge clk);
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
